// File: rtl/can_cfg_pkg.sv
package can_cfg_pkg;

  // Register bus geometry
  localparam int ADDR_W    = 5;   // Controller register address width
  localparam int DATA_W    = 16;  // Controller register data width
  localparam int ID_W      = 11;  // Standard CAN identifier
  localparam int MDATA_W   = 64;  // Eight payload bytes
  localparam int STEP_W    = 3;   // Wide enough for the longest address list

  // Address list lengths
  localparam int MSG_STEPS = 7;   // Id, four data words, general, control
  localparam int RST_STEPS = 2;   // General, then interrupt clear

  // Controller register map
  localparam logic [ADDR_W-1:0] ADDR_TX_ID   = 5'h0C;  // Transmit identifier
  localparam logic [ADDR_W-1:0] ADDR_TX_D12  = 5'h0A;  // Transmit data bytes 1 and 3
  localparam logic [ADDR_W-1:0] ADDR_TX_D34  = 5'h09;  // Transmit data bytes 2 and 4
  localparam logic [ADDR_W-1:0] ADDR_TX_D56  = 5'h08;  // Transmit data bytes 8 and 7
  localparam logic [ADDR_W-1:0] ADDR_TX_D78  = 5'h07;  // Transmit data bytes 6 and 5
  localparam logic [ADDR_W-1:0] ADDR_GENERAL = 5'h0E;  // General register
  localparam logic [ADDR_W-1:0] ADDR_TX_CTRL = 5'h0D;  // Transmission control
  localparam logic [ADDR_W-1:0] ADDR_IRQ     = 5'h12;  // Interrupt register

  // Fixed register contents
  localparam logic [DATA_W-1:0] TX_CTRL_VAL = 16'h8008;  // Request transmit
  localparam logic [DATA_W-1:0] RST_IRQ_VAL = 16'h8070;  // Clear pending interrupts
  localparam logic [DATA_W-1:0] GENERAL_VAL = 16'h009C;  // Default general setup

  // Host command opcodes
  typedef enum logic [2:0] {
    OP_NONE,       // No command
    OP_INIT,       // Single config word
    OP_WRITE,      // Host transmit message
    OP_TRIM,       // Fixed max-transition message
    OP_RESET_BUS   // General plus interrupt clear
  } can_op_e;

  // Sequencer states
  typedef enum logic {
    ST_IDLE,  // Waiting for a command
    ST_RUN    // Walking the address list
  } seq_state_e;

  // CAN frame as the host hands it over, byte 1 in data[63:56]
  typedef struct packed {
    logic [ID_W-1:0]    id;
    logic [MDATA_W-1:0] data;
  } can_msg_t;

  // Decoded command
  typedef struct packed {
    can_op_e            op;
    logic [ADDR_W-1:0]  init_addr;  // Only meaningful for OP_INIT
    logic [DATA_W-1:0]  init_data;  // Only meaningful for OP_INIT
    can_msg_t           msg;        // Host or trim message
  } cmd_t;

  // One register bus write
  typedef struct packed {
    logic              valid;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
  } reg_write_t;

  // Alternating bits give the most transitions on the wire
  localparam can_msg_t TRIM_MSG = '{id: 11'h555, data: 64'hAAAA_AAAA_AAAA_AAAA};

  // Write order of a transmit message, index 0 goes first
  localparam logic [ADDR_W-1:0] MSG_ADDR_LIST [MSG_STEPS] = '{
    ADDR_TX_ID, ADDR_TX_D12, ADDR_TX_D34, ADDR_TX_D56,
    ADDR_TX_D78, ADDR_GENERAL, ADDR_TX_CTRL
  };

  // Write order of a bus reset
  localparam logic [ADDR_W-1:0] RST_ADDR_LIST [RST_STEPS] = '{
    ADDR_GENERAL, ADDR_IRQ
  };

endpackage

// File: rtl/can_cmd_decode.sv
`timescale 1ns/1ps

module can_cmd_decode (
  input  logic                                    clk,
  input  logic                                    reset,
  input  logic                                    initi,      // Init strobe
  input  logic                                    write,      // Transmit strobe
  input  logic                                    reset_can,  // Bus reset strobe
  input  logic                                    trim,       // Trim message strobe
  input  logic [can_cfg_pkg::ADDR_W-1:0]          init_addr,
  input  logic [can_cfg_pkg::DATA_W-1:0]          init_data,
  input  can_cfg_pkg::can_msg_t                   tx_msg,
  input  logic                                    busy,       // Sequencer still working
  output can_cfg_pkg::cmd_t                       cmd,
  output logic                                    cmd_valid,  // One-cycle pulse
  output logic                                    cmd_err     // More than one strobe
);

  logic [3:0]           strobes;  // Init, write, reset, trim from the top bit down
  can_cfg_pkg::can_op_e op_sel;   // Opcode for a one-hot set
  logic                 multi;    // Non one-hot set
  logic                 accept;   // Legal command taken this cycle

  assign strobes = {initi, write, reset_can, trim};

  // Strobe set to opcode
  always_comb begin
    op_sel = can_cfg_pkg::OP_NONE;
    multi  = 1'b0;
    case (strobes)
      4'b1000: op_sel = can_cfg_pkg::OP_INIT;
      4'b0100: op_sel = can_cfg_pkg::OP_WRITE;
      4'b0010: op_sel = can_cfg_pkg::OP_RESET_BUS;
      4'b0001: op_sel = can_cfg_pkg::OP_TRIM;
      4'b0000: op_sel = can_cfg_pkg::OP_NONE;  // Quiet cycle
      default: multi  = 1'b1;                  // Two or more at once
    endcase
  end

  assign accept = !busy && (op_sel != can_cfg_pkg::OP_NONE);  // Busy drops it silently

  always_ff @(posedge clk) begin
    if (reset) begin
      cmd_valid <= 1'b0;
      cmd_err   <= 1'b0;
    end else begin
      cmd_valid <= accept;
      cmd_err   <= !busy && multi;  // Only flagged when a command could start
    end
  end

  // Operand capture
  always_ff @(posedge clk) begin
    if (accept) begin
      cmd.op        <= op_sel;
      cmd.init_addr <= init_addr;
      cmd.init_data <= init_data;
      cmd.msg       <= (op_sel == can_cfg_pkg::OP_TRIM) ? can_cfg_pkg::TRIM_MSG
                                                        : tx_msg;  // Trim ignores host msg
    end
  end

endmodule

// File: rtl/can_reg_sequencer.sv
`timescale 1ns/1ps

module can_reg_sequencer (
  input  logic                           clk,
  input  logic                           reset,
  input  can_cfg_pkg::cmd_t              cmd,         // From decoder
  input  logic                           cmd_valid,   // Start pulse
  output logic                           step_valid,  // One address this cycle
  output logic [can_cfg_pkg::ADDR_W-1:0] step_addr,
  output can_cfg_pkg::cmd_t              step_cmd,    // Latched command
  output logic                           step_last,   // Final address of the list
  output logic                           busy
);

  can_cfg_pkg::seq_state_e         state;
  logic [can_cfg_pkg::STEP_W-1:0]  cnt;       // Index of the next step
  logic [can_cfg_pkg::STEP_W-1:0]  n_start;   // List length of the incoming command
  logic [can_cfg_pkg::STEP_W-1:0]  last_idx;  // Last index of the running command
  logic                            start;

  // Number of writes per opcode
  function automatic logic [can_cfg_pkg::STEP_W-1:0] steps_of(can_cfg_pkg::can_op_e op);
    case (op)
      can_cfg_pkg::OP_INIT:      steps_of = 3'd1;
      can_cfg_pkg::OP_WRITE,
      can_cfg_pkg::OP_TRIM:      steps_of = can_cfg_pkg::STEP_W'(can_cfg_pkg::MSG_STEPS);
      can_cfg_pkg::OP_RESET_BUS: steps_of = can_cfg_pkg::STEP_W'(can_cfg_pkg::RST_STEPS);
      default:                   steps_of = '0;
    endcase
  endfunction

  // Address of step idx for a command
  function automatic logic [can_cfg_pkg::ADDR_W-1:0] addr_of(can_cfg_pkg::cmd_t c,
                                                             logic [can_cfg_pkg::STEP_W-1:0] idx);
    addr_of = '0;
    case (c.op)
      can_cfg_pkg::OP_INIT: addr_of = c.init_addr;  // Host chosen register
      can_cfg_pkg::OP_WRITE,
      can_cfg_pkg::OP_TRIM: begin
        if (idx < can_cfg_pkg::STEP_W'(can_cfg_pkg::MSG_STEPS))
          addr_of = can_cfg_pkg::MSG_ADDR_LIST[idx];
      end
      can_cfg_pkg::OP_RESET_BUS: begin
        if (idx < can_cfg_pkg::STEP_W'(can_cfg_pkg::RST_STEPS))
          addr_of = can_cfg_pkg::RST_ADDR_LIST[idx[0]];
      end
      default: addr_of = '0;
    endcase
  endfunction

  assign start    = (state == can_cfg_pkg::ST_IDLE) && cmd_valid;
  assign n_start  = steps_of(cmd.op);
  assign last_idx = steps_of(step_cmd.op) - 3'd1;
  assign busy     = cmd_valid || (state == can_cfg_pkg::ST_RUN);  // Pending counts too

  always_ff @(posedge clk) begin
    if (reset) begin
      state      <= can_cfg_pkg::ST_IDLE;
      cnt        <= '0;
      step_valid <= 1'b0;
      step_last  <= 1'b0;
    end else begin
      step_valid <= 1'b0;
      step_last  <= 1'b0;
      case (state)
        can_cfg_pkg::ST_IDLE: begin
          if (cmd_valid) begin
            step_valid <= 1'b1;               // Step 0 right away
            step_last  <= (n_start == 3'd1);  // Init is a single write
            cnt        <= 3'd1;
            if (n_start != 3'd1)
              state <= can_cfg_pkg::ST_RUN;
          end
        end
        can_cfg_pkg::ST_RUN: begin
          step_valid <= 1'b1;
          step_last  <= (cnt == last_idx);
          cnt        <= cnt + 3'd1;
          if (cnt == last_idx)
            state <= can_cfg_pkg::ST_IDLE;  // Busy drops with the last step
        end
        default: state <= can_cfg_pkg::ST_IDLE;
      endcase
    end
  end

  // Step payload
  always_ff @(posedge clk) begin
    if (start) begin
      step_cmd  <= cmd;
      step_addr <= addr_of(cmd, '0);
    end else if (state == can_cfg_pkg::ST_RUN) begin
      step_addr <= addr_of(step_cmd, cnt);
    end
  end

endmodule

// File: rtl/can_write_data.sv
`timescale 1ns/1ps

module can_write_data (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           step_valid,
  input  logic [can_cfg_pkg::ADDR_W-1:0] step_addr,
  input  can_cfg_pkg::cmd_t              step_cmd,
  input  logic                           step_last,
  output can_cfg_pkg::reg_write_t        reg_wr,     // Registered bus write
  output logic                           done        // With the last write
);

  logic [can_cfg_pkg::DATA_W-1:0] word;  // Value for the current step

  // Split a message into the word of one transmit register
  function automatic logic [can_cfg_pkg::DATA_W-1:0] msg_word(can_cfg_pkg::can_msg_t m,
                                                              logic [can_cfg_pkg::ADDR_W-1:0] a);
    logic [can_cfg_pkg::MDATA_W-1:0] d;
    d = m.data;
    case (a)
      can_cfg_pkg::ADDR_TX_ID:   msg_word = {m.id, 5'h0};           // Id left aligned
      can_cfg_pkg::ADDR_TX_D12:  msg_word = {d[63:56], d[47:40]};   // Bytes 1 and 3
      can_cfg_pkg::ADDR_TX_D34:  msg_word = {d[55:48], d[39:32]};   // Bytes 2 and 4
      can_cfg_pkg::ADDR_TX_D56:  msg_word = {d[7:0], d[15:8]};      // Bytes 8 and 7
      can_cfg_pkg::ADDR_TX_D78:  msg_word = {d[23:16], d[31:24]};   // Bytes 6 and 5
      can_cfg_pkg::ADDR_GENERAL: msg_word = can_cfg_pkg::GENERAL_VAL;
      can_cfg_pkg::ADDR_TX_CTRL: msg_word = can_cfg_pkg::TX_CTRL_VAL;  // Kicks off transmit
      default:                   msg_word = '0;
    endcase
  endfunction

  // Address and opcode to register value
  always_comb begin
    case (step_cmd.op)
      can_cfg_pkg::OP_INIT: word = step_cmd.init_data;  // Passed through as given
      can_cfg_pkg::OP_WRITE,
      can_cfg_pkg::OP_TRIM: word = msg_word(step_cmd.msg, step_addr);  // Trim msg set in decode
      can_cfg_pkg::OP_RESET_BUS: begin
        case (step_addr)
          can_cfg_pkg::ADDR_GENERAL: word = can_cfg_pkg::GENERAL_VAL;
          can_cfg_pkg::ADDR_IRQ:     word = can_cfg_pkg::RST_IRQ_VAL;  // Clear interrupts
          default:                   word = '0;
        endcase
      end
      default: word = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      reg_wr <= '0;  // Addr and data read as zero after reset
      done   <= 1'b0;
    end else begin
      reg_wr.valid <= step_valid;
      done         <= step_valid && step_last;
      if (step_valid) begin
        reg_wr.addr <= step_addr;
        reg_wr.data <= word;  // Held between commands
      end
    end
  end

endmodule

// File: rtl/can_cfg_writer.sv
`timescale 1ns/1ps

module can_cfg_writer (
  input  logic                           clk,
  input  logic                           reset,
  input  logic                           initi,
  input  logic                           write,
  input  logic                           reset_can,
  input  logic                           trim,
  input  logic [can_cfg_pkg::ADDR_W-1:0] init_addr,
  input  logic [can_cfg_pkg::DATA_W-1:0] init_data,
  input  can_cfg_pkg::can_msg_t          tx_msg,
  output can_cfg_pkg::reg_write_t        reg_wr,     // To the controller register bus
  output logic                           busy,       // Command in flight
  output logic                           done,       // Last write of a command
  output logic                           cmd_err     // Rejected strobe set
);

  can_cfg_pkg::cmd_t              cmd;         // Decoder to sequencer
  logic                           cmd_valid;
  logic                           step_valid;  // Sequencer to write data
  logic [can_cfg_pkg::ADDR_W-1:0] step_addr;
  can_cfg_pkg::cmd_t              step_cmd;
  logic                           step_last;

  can_cmd_decode u_decode (
    .clk       (clk),
    .reset     (reset),
    .initi     (initi),
    .write     (write),
    .reset_can (reset_can),
    .trim      (trim),
    .init_addr (init_addr),
    .init_data (init_data),
    .tx_msg    (tx_msg),
    .busy      (busy),        // Gates strobe sampling
    .cmd       (cmd),
    .cmd_valid (cmd_valid),
    .cmd_err   (cmd_err)
  );

  can_reg_sequencer u_seq (
    .clk        (clk),
    .reset      (reset),
    .cmd        (cmd),
    .cmd_valid  (cmd_valid),
    .step_valid (step_valid),
    .step_addr  (step_addr),
    .step_cmd   (step_cmd),
    .step_last  (step_last),
    .busy       (busy)
  );

  can_write_data u_wdata (
    .clk        (clk),
    .reset      (reset),
    .step_valid (step_valid),
    .step_addr  (step_addr),
    .step_cmd   (step_cmd),
    .step_last  (step_last),
    .reg_wr     (reg_wr),
    .done       (done)
  );

endmodule

// File: verification/can_cfg_writer_props.sv
`timescale 1ns/1ps

module can_cfg_writer_props (
  input logic                    clk,
  input logic                    reset,
  input can_cfg_pkg::reg_write_t reg_wr,
  input logic                    done,
  input logic                    cmd_err
);

  int err_cnt = 0;  // Failed assertions so far

  // Bus stays quiet while held in reset
  a_quiet_in_reset: assert property (@(posedge clk) reset |=> !reg_wr.valid)
    else begin
      $error("reg_wr.valid high during reset");
      err_cnt++;
    end

  // Last write marker only on a real write
  a_done_on_write: assert property (@(posedge clk) disable iff (reset)
    done |-> reg_wr.valid)
    else begin
      $error("done without reg_wr.valid");
      err_cnt++;
    end

  // Rejected strobes never start a write burst two cycles on
  a_err_no_start: assert property (@(posedge clk) disable iff (reset)
    cmd_err |-> ##2 !$rose(reg_wr.valid))
    else begin
      $error("write burst started by a rejected strobe set");
      err_cnt++;
    end

endmodule

bind can_cfg_writer can_cfg_writer_props u_props (
  .clk     (clk),
  .reset   (reset),
  .reg_wr  (reg_wr),
  .done    (done),
  .cmd_err (cmd_err)
);

// File: verification/can_cfg_writer_tb.sv
`timescale 1ns/1ps

module can_cfg_writer_tb;

  typedef struct packed {
    can_cfg_pkg::can_op_e           op;
    logic                           dual;  // Extra initi that must be rejected
    logic                           poke;  // Extra initi while busy
    logic [can_cfg_pkg::ADDR_W-1:0] addr;
    logic [can_cfg_pkg::DATA_W-1:0] data;
    can_cfg_pkg::can_msg_t          msg;
  } row_t;

  localparam int ROWS         = 10;
  localparam int RESET_CYCLES = 10;
  localparam int IDLE_CYCLES  = 4;
  localparam int TIMEOUT      = ROWS * 12 + RESET_CYCLES + IDLE_CYCLES + 2;  // 12 per row max

  logic                           clk;
  logic                           reset;
  logic                           initi;
  logic                           write;
  logic                           reset_can;
  logic                           trim;
  logic [can_cfg_pkg::ADDR_W-1:0] init_addr;
  logic [can_cfg_pkg::DATA_W-1:0] init_data;
  can_cfg_pkg::can_msg_t          tx_msg;
  can_cfg_pkg::reg_write_t        reg_wr;
  logic                           busy;
  logic                           done;
  logic                           cmd_err;

  row_t                    rows [ROWS];  // Stimulus table
  can_cfg_pkg::reg_write_t exp_q [$];    // Expected writes of the current row
  int                      seed     = 13825;
  int                      cycles   = 0;

  can_cfg_writer dut (
    .clk       (clk),
    .reset     (reset),
    .initi     (initi),
    .write     (write),
    .reset_can (reset_can),
    .trim      (trim),
    .init_addr (init_addr),
    .init_data (init_data),
    .tx_msg    (tx_msg),
    .reg_wr    (reg_wr),
    .busy      (busy),
    .done      (done),
    .cmd_err   (cmd_err)
  );

  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;  // 10 ns period
  end

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > TIMEOUT) begin
      $display("Timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Simulation failed");
      $fatal(1, "cycle limit reached");
    end
  end

  task automatic check_write(input can_cfg_pkg::reg_write_t got,
                             input can_cfg_pkg::reg_write_t exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got valid %b addr %h data %h", $time, what,
               got.valid, got.addr, got.data);
      $display("  expected valid %b addr %h data %h", exp.valid, exp.addr, exp.data);
      $display("Simulation failed");
      $fatal(1, "bus write check");
    end
  endtask

  task automatic check_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s got %b expected %b", $time, what, got, exp);
      $display("Simulation failed");
      $fatal(1, "flag check");
    end
  endtask

  // Byte n of the payload with byte 1 first on the wire
  function automatic logic [7:0] byte_of(can_cfg_pkg::can_msg_t m, int n);
    byte_of = m.data[71 - 8 * n -: 8];
  endfunction

  function automatic can_cfg_pkg::reg_write_t bus_write(logic [can_cfg_pkg::ADDR_W-1:0] a,
                                                       logic [can_cfg_pkg::DATA_W-1:0] d);
    can_cfg_pkg::reg_write_t w;
    w.valid = 1'b1;
    w.addr  = a;
    w.data  = d;
    return w;
  endfunction

  // Reference model of the write list of one row
  task automatic build_expected(input row_t r);
    can_cfg_pkg::can_msg_t m;
    exp_q.delete();
    m = (r.op == can_cfg_pkg::OP_TRIM) ? can_cfg_pkg::TRIM_MSG : r.msg;  // Host msg ignored
    if (!r.dual) begin
      case (r.op)
        can_cfg_pkg::OP_INIT: exp_q.push_back(bus_write(r.addr, r.data));
        can_cfg_pkg::OP_WRITE,
        can_cfg_pkg::OP_TRIM: begin
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_TX_ID, {m.id, 5'b0}));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_TX_D12, {byte_of(m, 1), byte_of(m, 3)}));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_TX_D34, {byte_of(m, 2), byte_of(m, 4)}));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_TX_D56, {byte_of(m, 8), byte_of(m, 7)}));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_TX_D78, {byte_of(m, 6), byte_of(m, 5)}));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_GENERAL, can_cfg_pkg::GENERAL_VAL));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_TX_CTRL, can_cfg_pkg::TX_CTRL_VAL));
        end
        can_cfg_pkg::OP_RESET_BUS: begin
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_GENERAL, can_cfg_pkg::GENERAL_VAL));
          exp_q.push_back(bus_write(can_cfg_pkg::ADDR_IRQ, can_cfg_pkg::RST_IRQ_VAL));
        end
        default: ;
      endcase
    end
  endtask

  task automatic fill_rows();
    logic [31:0] r32;
    for (int i = 0; i < ROWS; i++) begin
      r32              = $random(seed);
      rows[i]          = '0;
      rows[i].addr     = r32[4:0];
      rows[i].data     = r32[31:16];
      rows[i].msg.id   = r32[15:5];
      rows[i].msg.data = {$random(seed), $random(seed)};
    end
    rows[0].op       = can_cfg_pkg::OP_INIT;
    rows[0].addr     = 5'h03;
    rows[0].data     = 16'h1234;
    rows[1].op       = can_cfg_pkg::OP_WRITE;
    rows[1].msg.id   = 11'h7FF;
    rows[1].msg.data = 64'h0102_0304_0506_0708;  // Distinct bytes expose swaps
    rows[2].op       = can_cfg_pkg::OP_WRITE;
    rows[2].poke     = 1'b1;
    rows[3].op       = can_cfg_pkg::OP_TRIM;     // Random tx_msg must not leak
    rows[4].op       = can_cfg_pkg::OP_RESET_BUS;
    rows[5].op       = can_cfg_pkg::OP_WRITE;
    rows[5].dual     = 1'b1;                     // initi plus write
    rows[6].op       = can_cfg_pkg::OP_INIT;
    rows[7].op       = can_cfg_pkg::OP_TRIM;
    rows[7].dual     = 1'b1;                     // initi plus trim
    rows[8].op       = can_cfg_pkg::OP_WRITE;
    rows[9].op       = can_cfg_pkg::OP_RESET_BUS;
  endtask

  task automatic drive_strobes(input row_t r);
    initi     = r.dual || (r.op == can_cfg_pkg::OP_INIT);
    write     = (r.op == can_cfg_pkg::OP_WRITE);
    reset_can = (r.op == can_cfg_pkg::OP_RESET_BUS);
    trim      = (r.op == can_cfg_pkg::OP_TRIM);
  endtask

  task automatic clear_strobes();
    initi     = 1'b0;
    write     = 1'b0;
    reset_can = 1'b0;
    trim      = 1'b0;
  endtask

  // One command with its first write two edges after the strobe edge
  task automatic run_row(input row_t r);
    int n;
    build_expected(r);
    n = exp_q.size();
    @(posedge clk);
    #1;
    init_addr = r.addr;
    init_data = r.data;
    tx_msg    = r.msg;
    drive_strobes(r);
    for (int cyc = 0; cyc < n + 4; cyc++) begin
      @(posedge clk);  // cyc 0 is the strobe edge
      #1;
      clear_strobes();
      if (r.poke && cyc == n - 1)
        initi = 1'b1;  // Lands in the last busy cycle and is dropped
      @(negedge clk);
      check_flag(cmd_err, r.dual && cyc == 0, "cmd_err");
      check_flag(busy, cyc < n, "busy");
      if (cyc >= 2 && cyc < n + 2) begin
        check_write(reg_wr, exp_q[cyc - 2], "reg_wr");
        check_flag(done, cyc == n + 1, "done");
      end else begin
        check_flag(reg_wr.valid, 1'b0, "reg_wr.valid outside command");
        check_flag(done, 1'b0, "done outside command");
      end
    end
  endtask

  initial begin
    reset     = 1'b1;
    init_addr = '0;
    init_data = '0;
    tx_msg    = '0;
    clear_strobes();
    fill_rows();
    repeat (RESET_CYCLES) @(posedge clk);
    #1 reset = 1'b0;
    for (int i = 0; i < IDLE_CYCLES; i++) begin  // Quiet bus after reset
      @(negedge clk);
      check_write(reg_wr, '0, "reg_wr after reset");
      check_flag(busy, 1'b0, "busy after reset");
      check_flag(done, 1'b0, "done after reset");
      check_flag(cmd_err, 1'b0, "cmd_err after reset");
    end
    for (int i = 0; i < ROWS; i++)
      run_row(rows[i]);
    if (dut.u_props.err_cnt == 0)
      $display("Simulation passed");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

// File: verilog.f
rtl/can_cfg_pkg.sv
rtl/can_cmd_decode.sv
rtl/can_reg_sequencer.sv
rtl/can_write_data.sv
rtl/can_cfg_writer.sv
verification/can_cfg_writer_props.sv
verification/can_cfg_writer_tb.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= can_cfg_writer_tb
FLIST     ?= verilog.f
PASS_MSG  := Simulation passed

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: build
	@out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FLIST)

clean:
	rm -rf obj_dir
